// File: all.f
source/vertex_job_pkg.sv
source/sync_fifo.sv
source/job_sequencer.sv
source/line_unpacker.sv
source/record_assembler.sv
source/vertex_job_top.sv
tests/tb_line_memory.sv
tests/tb_vertex_job.sv

// File: tests/tb_vertex_job.sv
// testbench top for the vertex job controller: directed jobs, command and record checks
`timescale 1ns/100ps
`default_nettype none

module tb_vertex_job;

	localparam logic [31:0] LCG_SEED   = 32'h6c93be1f;
	localparam int          WAIT_LIMIT = 4000;

	logic                                  clock;
	logic                                  rstn;
	logic                                  job_valid;
	logic                                  job_ready;
	logic [vertex_job_pkg::ADDR_BITS-1:0]  out_degree_base;
	logic [vertex_job_pkg::ADDR_BITS-1:0]  edges_idx_base;
	logic [vertex_job_pkg::COUNT_BITS-1:0] num_vertices;
	logic [vertex_job_pkg::COUNT_BITS-1:0] first_id;
	logic                                  cmd_valid;
	logic                                  cmd_ready;
	vertex_job_pkg::read_cmd_t             cmd;
	logic                                  data_valid;
	vertex_job_pkg::array_sel_t            data_sel;
	logic [vertex_job_pkg::LINE_BITS-1:0]  data_line;
	logic                                  vert_valid;
	logic                                  vert_ready;
	vertex_job_pkg::vertex_rec_t           vert;
	logic                                  busy;

	logic                                  grant_en;
	logic                                  rand_vert;
	logic                                  rand_grant;
	logic                                  hold_cmd;
	logic [31:0]                           lcg_state;
	int                                    errors;
	int                                    cmds_checked;
	int                                    recs_checked;
	int                                    stall_cycles;
	logic                                  stalled;
	vertex_job_pkg::read_cmd_t             stalled_cmd;
	vertex_job_pkg::read_cmd_t             cmd_q[$];
	vertex_job_pkg::vertex_rec_t           rec_q[$];

	vertex_job_top DUT (
		.clock(clock), .rstn(rstn),
		.job_valid(job_valid), .job_ready(job_ready),
		.out_degree_base(out_degree_base), .edges_idx_base(edges_idx_base),
		.num_vertices(num_vertices), .first_id(first_id),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
		.data_valid(data_valid), .data_sel(data_sel), .data_line(data_line),
		.vert_valid(vert_valid), .vert_ready(vert_ready), .vert(vert), .busy(busy)
	);

	tb_line_memory u_memory (
		.clock(clock), .rstn(rstn), .grant_en(grant_en),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
		.data_valid(data_valid), .data_sel(data_sel), .data_line(data_line)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// element value of vertex idx, same address pattern the memory serves
	function automatic logic [31:0] expected_elem(input logic [31:0] base, input int idx,
		input vertex_job_pkg::array_sel_t sel);
		logic [31:0] value;
		value = base + 32'(4 * idx);
		value[31] = sel;
		return value;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// ready patterns and port monitors
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		lcg_state  <= lcg_next(lcg_state);
		vert_ready <= rand_vert ? lcg_state[17] : 1'b1;
		grant_en   <= hold_cmd ? 1'b0 : (rand_grant ? lcg_state[23] : 1'b1);
	end

	always @(posedge clock) begin
		if (rstn) begin
			if (cmd_valid && cmd_ready)
				cmd_q.push_back(cmd);
			if (vert_valid && vert_ready)
				rec_q.push_back(vert);
			// a stalled command must hold until taken
			if (stalled) begin
				stall_cycles++;
				assert (cmd_valid && cmd == stalled_cmd)
				else report_mismatch($sformatf("stalled command changed to %h from %h",
					cmd, stalled_cmd));
			end
			stalled = cmd_valid && !cmd_ready;
			stalled_cmd = cmd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string msg);
		errors++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	task automatic print_summary();
		$display("%0d errors, %0d commands and %0d records checked",
			errors, cmds_checked, recs_checked);
	endtask

	task automatic abort_run(input string why);
		$display("run stopped: %s", why);
		print_summary();
		$display("** FAIL **");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// job driving and waiting
	//////////////////////////////////////////////////////////////////////

	task automatic drive_job(input logic [31:0] od, input logic [31:0] ei, input int n,
		input logic [15:0] first);
		int t;
		@(posedge clock);
		job_valid       <= 1'b1;
		out_degree_base <= od;
		edges_idx_base  <= ei;
		num_vertices    <= 16'(n);
		first_id        <= first;
		t = 0;
		do begin
			@(posedge clock);
			t++;
		end while (!job_ready && t < WAIT_LIMIT);
		job_valid <= 1'b0;
		if (!job_ready)
			abort_run("the DUT never accepted the job");
	endtask

	task automatic wait_job_end();
		int t;
		t = 0;
		@(posedge clock);
		assert (busy) else report_mismatch("busy is low right after job acceptance");
		while (busy && t < WAIT_LIMIT) begin
			@(posedge clock);
			t++;
		end
		if (busy)
			abort_run("busy never fell at the end of the job");
	endtask

	task automatic wait_records(input int total);
		int t;
		t = 0;
		while (rec_q.size() < total && t < WAIT_LIMIT) begin
			@(posedge clock);
			t++;
		end
		if (rec_q.size() < total) begin
			abort_run("records still missing after the timeout");
		end else begin
			// room for any extra record to show up
			repeat (4) @(posedge clock);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// expected commands and records
	//////////////////////////////////////////////////////////////////////

	task automatic compare_cmd(input int idx, input vertex_job_pkg::read_cmd_t exp);
		vertex_job_pkg::read_cmd_t got;
		got = '0;
		if (idx < cmd_q.size())
			got = cmd_q[idx];
		cmds_checked++;
		assert (idx < cmd_q.size() && got == exp)
		else report_mismatch($sformatf("command %0d: got %h/%0d/%0d, expected %h/%0d/%0d",
			idx, got.addr, got.sel, got.real_size, exp.addr, exp.sel, exp.real_size));
	endtask

	task automatic check_cmds(input int first_idx, input logic [31:0] od,
		input logic [31:0] ei, input int n);
		vertex_job_pkg::read_cmd_t exp;
		int                        j;
		int                        left;
		for (j = 0; j * vertex_job_pkg::ELEMS_PER_LINE < n; j++) begin
			left = n - j * vertex_job_pkg::ELEMS_PER_LINE;
			exp.real_size = 4'((left > vertex_job_pkg::ELEMS_PER_LINE)
				? vertex_job_pkg::ELEMS_PER_LINE : left);
			exp.addr = od + 32'(j * vertex_job_pkg::LINE_BYTES);
			exp.sel  = vertex_job_pkg::ARR_OUT_DEGREE;
			compare_cmd(first_idx + 2 * j, exp);
			exp.addr = ei + 32'(j * vertex_job_pkg::LINE_BYTES);
			exp.sel  = vertex_job_pkg::ARR_EDGES_IDX;
			compare_cmd(first_idx + 2 * j + 1, exp);
		end
	endtask

	task automatic check_recs(input int first_idx, input logic [31:0] od,
		input logic [31:0] ei, input int n, input logic [15:0] first);
		vertex_job_pkg::vertex_rec_t exp;
		vertex_job_pkg::vertex_rec_t got;
		int                          i;
		for (i = 0; i < n; i++) begin
			exp.id             = first + 16'(i);
			exp.inv_out_degree = expected_elem(od, i, vertex_job_pkg::ARR_OUT_DEGREE);
			exp.inv_edges_idx  = expected_elem(ei, i, vertex_job_pkg::ARR_EDGES_IDX);
			got = '0;
			if (first_idx + i < rec_q.size())
				got = rec_q[first_idx + i];
			recs_checked++;
			assert (got == exp)
			else report_mismatch($sformatf("record %0d: got %h, expected %h",
				first_idx + i, got, exp));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		assert (!cmd_valid && !vert_valid && !busy && job_ready)
		else report_mismatch($sformatf("after reset cmd_valid %b vert_valid %b busy %b ready %b",
			cmd_valid, vert_valid, busy, job_ready));
	endtask

	task automatic run_job_and_check(input logic [31:0] od, input logic [31:0] ei,
		input int n, input logic [15:0] first);
		drive_job(od, ei, n, first);
		wait_job_end();
		wait_records(n);
		check_cmds(0, od, ei, n);
		check_recs(0, od, ei, n, first);
		assert (cmd_q.size() == 2 * ((n + 7) / 8) && rec_q.size() == n)
		else report_mismatch($sformatf("job of %0d: %0d commands and %0d records seen",
			n, cmd_q.size(), rec_q.size()));
		cmd_q.delete();
		rec_q.delete();
	endtask

	// second job follows as soon as the first one drops busy
	task automatic back_to_back_jobs();
		drive_job(32'h0000_4000, 32'h0007_0000, 11, 16'd500);
		wait_job_end();
		repeat (2) @(posedge clock);
		assert (rec_q.size() == 11)
		else report_mismatch($sformatf("%0d of 11 records out after busy fell", rec_q.size()));
		drive_job(32'h0000_5000, 32'h0008_0000, 6, 16'd40);
		wait_job_end();
		repeat (2) @(posedge clock);
		assert (rec_q.size() == 17 && cmd_q.size() == 6)
		else report_mismatch($sformatf("%0d records and %0d commands after two jobs",
			rec_q.size(), cmd_q.size()));
		check_cmds(0, 32'h0000_4000, 32'h0007_0000, 11);
		check_cmds(4, 32'h0000_5000, 32'h0008_0000, 6);
		check_recs(0, 32'h0000_4000, 32'h0007_0000, 11, 16'd500);
		check_recs(11, 32'h0000_5000, 32'h0008_0000, 6, 16'd40);
		cmd_q.delete();
		rec_q.delete();
	endtask

	initial begin
		rstn            = 1'b0;
		job_valid       = 1'b0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		num_vertices    = '0;
		first_id        = '0;
		vert_ready      = 1'b1;
		grant_en        = 1'b1;
		rand_vert       = 1'b0;
		rand_grant      = 1'b0;
		hold_cmd        = 1'b0;
		lcg_state       = LCG_SEED;
		errors          = 0;
		cmds_checked    = 0;
		recs_checked    = 0;
		stall_cycles    = 0;
		stalled         = 1'b0;
		stalled_cmd     = '0;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		check_reset_state();

		run_job_and_check(32'h0000_1000, 32'h0004_0000, 5, 16'd100);
		run_job_and_check(32'h0000_2000, 32'h0005_0000, 20, 16'd7);

		// random record and command back-pressure
		rand_vert  <= 1'b1;
		rand_grant <= 1'b1;
		run_job_and_check(32'h0000_6000, 32'h0009_0000, 40, 16'd300);
		rand_vert  <= 1'b0;
		rand_grant <= 1'b0;

		// command port held off for a stretch
		hold_cmd <= 1'b1;
		stall_cycles = 0;
		fork
			run_job_and_check(32'h0000_2000, 32'h0005_0000, 20, 16'd7);
			begin
				repeat (40) @(posedge clock);
				hold_cmd <= 1'b0;
			end
		join
		assert (stall_cycles > 0) else report_mismatch("no command stall was seen");

		back_to_back_jobs();

		print_summary();
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_line_memory.sv
// testbench memory model: grants read commands and returns address-derived lines after a delay
`timescale 1ns/100ps
`default_nettype none

module tb_line_memory #(
	parameter int DELAY = 4
) (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 grant_en,
	input  logic                                 cmd_valid,
	output logic                                 cmd_ready,
	input  vertex_job_pkg::read_cmd_t            cmd,
	output logic                                 data_valid,
	output vertex_job_pkg::array_sel_t           data_sel,
	output logic [vertex_job_pkg::LINE_BITS-1:0] data_line
);

	vertex_job_pkg::read_cmd_t pend_q[$];
	int                        due_q[$];
	int                        cycle;

	// element k holds its own byte address, the array tag sits in bit 31
	function automatic logic [vertex_job_pkg::LINE_BITS-1:0] make_line(
		input vertex_job_pkg::read_cmd_t c);
		logic [vertex_job_pkg::LINE_BITS-1:0] line;
		logic [31:0]                          elem;
		int                                   k;
		line = '0;
		for (k = 0; k < vertex_job_pkg::ELEMS_PER_LINE; k++) begin
			elem = c.addr + 32'(4 * k);
			elem[31] = c.sel;
			line[k*vertex_job_pkg::ELEM_BITS +: vertex_job_pkg::ELEM_BITS] = elem;
		end
		return line;
	endfunction

	initial begin
		cmd_ready  = 1'b0;
		data_valid = 1'b0;
		data_sel   = vertex_job_pkg::ARR_OUT_DEGREE;
		data_line  = '0;
		cycle      = 0;
	end

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (!rstn) begin
			cmd_ready  <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			cmd_ready <= grant_en;
			if (cmd_valid && cmd_ready) begin
				pend_q.push_back(cmd);
				due_q.push_back(cycle + DELAY);
			end
			// one line per cycle, oldest first
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				data_valid <= 1'b1;
				data_sel   <= pend_q[0].sel;
				data_line  <= make_line(pend_q[0]);
				pend_q.delete(0);
				due_q.delete(0);
			end else begin
				data_valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/vertex_job_top.sv
// top of the vertex job controller, joining sequencer, unpackers, assembler and queues
`timescale 1ns/100ps
`default_nettype none

module vertex_job_top (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  job_valid,
	output logic                                  job_ready,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0]  out_degree_base,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0]  edges_idx_base,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0] num_vertices,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0] first_id,
	output logic                                  cmd_valid,
	input  logic                                  cmd_ready,
	output vertex_job_pkg::read_cmd_t             cmd,
	input  logic                                  data_valid,
	input  vertex_job_pkg::array_sel_t            data_sel,
	input  logic [vertex_job_pkg::LINE_BITS-1:0]  data_line,
	output logic                                  vert_valid,
	input  logic                                  vert_ready,
	output vertex_job_pkg::vertex_rec_t           vert,
	output logic                                  busy
);

	logic                                      cmd_push;
	vertex_job_pkg::read_cmd_t                 cmd_push_data;
	logic                                      cmd_empty;
	logic [vertex_job_pkg::VERT_FREE_BITS-1:0] vert_free;
	logic                                      od_loaded;
	logic                                      ei_loaded;
	logic                                      line_clear;
	logic                                      shift;
	logic [vertex_job_pkg::COUNT_BITS-1:0]     line_first_id;
	logic [vertex_job_pkg::ELEM_BITS-1:0]      od_elem;
	logic [vertex_job_pkg::ELEM_BITS-1:0]      ei_elem;
	logic                                      rec_push;
	vertex_job_pkg::vertex_rec_t               rec;

	job_sequencer u_sequencer (
		.clock(clock), .rstn(rstn),
		.job_valid(job_valid), .job_ready(job_ready),
		.out_degree_base(out_degree_base), .edges_idx_base(edges_idx_base),
		.num_vertices(num_vertices), .first_id(first_id),
		.cmd_push(cmd_push), .cmd_push_data(cmd_push_data), .cmd_empty(cmd_empty),
		.vert_free(vert_free),
		.out_degree_loaded(od_loaded), .edges_idx_loaded(ei_loaded),
		.line_clear(line_clear), .shift(shift),
		.first_id_out(line_first_id), .busy(busy)
	);

	line_unpacker #(.ARRAY_SEL(vertex_job_pkg::ARR_OUT_DEGREE)) u_out_degree_unpacker (
		.clock(clock), .rstn(rstn),
		.data_valid(data_valid), .data_sel(data_sel), .data_line(data_line),
		.line_clear(line_clear), .shift(shift),
		.element(od_elem), .line_loaded(od_loaded)
	);

	line_unpacker #(.ARRAY_SEL(vertex_job_pkg::ARR_EDGES_IDX)) u_edges_idx_unpacker (
		.clock(clock), .rstn(rstn),
		.data_valid(data_valid), .data_sel(data_sel), .data_line(data_line),
		.line_clear(line_clear), .shift(shift),
		.element(ei_elem), .line_loaded(ei_loaded)
	);

	record_assembler u_assembler (
		.clock(clock), .rstn(rstn), .shift(shift), .first_id(line_first_id),
		.out_degree_elem(od_elem), .edges_idx_elem(ei_elem),
		.rec_push(rec_push), .rec(rec)
	);

	sync_fifo #(
		.payload_t(vertex_job_pkg::read_cmd_t),
		.DEPTH(vertex_job_pkg::CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clock(clock), .rstn(rstn),
		.push(cmd_push), .push_data(cmd_push_data), .pop(cmd_ready),
		.head(cmd), .valid(cmd_valid), .empty(cmd_empty), .free()
	);

	sync_fifo #(
		.payload_t(vertex_job_pkg::vertex_rec_t),
		.DEPTH(vertex_job_pkg::VERT_FIFO_DEPTH)
	) u_vert_fifo (
		.clock(clock), .rstn(rstn),
		.push(rec_push), .push_data(rec), .pop(vert_ready),
		.head(vert), .valid(vert_valid), .empty(), .free(vert_free)
	);

endmodule

`default_nettype wire

// File: source/record_assembler.sv
// pairs the two arrays' elements with a running vertex id into registered records
`timescale 1ns/100ps
`default_nettype none

module record_assembler (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  shift,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0] first_id,
	input  logic [vertex_job_pkg::ELEM_BITS-1:0]  out_degree_elem,
	input  logic [vertex_job_pkg::ELEM_BITS-1:0]  edges_idx_elem,
	output logic                                  rec_push,
	output vertex_job_pkg::vertex_rec_t           rec
);

	logic [vertex_job_pkg::COUNT_BITS-1:0] id_cnt;

	//////////////////////////////////////////////////////////////////////
	// id counter
	//////////////////////////////////////////////////////////////////////

	// shifts of one line are back to back, so reload between them
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			id_cnt   <= '0;
			rec_push <= 1'b0;
		end else begin
			rec_push <= shift;
			if (shift)
				id_cnt <= id_cnt + 1'b1;
			else
				id_cnt <= first_id;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// record register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (shift) begin
			rec.id             <= id_cnt;
			rec.inv_out_degree <= out_degree_elem;
			rec.inv_edges_idx  <= edges_idx_elem;
		end
	end

endmodule

`default_nettype wire

// File: source/line_unpacker.sv
// holds one array's data line and hands out one element per shift pulse
`timescale 1ns/100ps
`default_nettype none

module line_unpacker #(
	parameter vertex_job_pkg::array_sel_t ARRAY_SEL = vertex_job_pkg::ARR_OUT_DEGREE
) (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 data_valid,
	input  vertex_job_pkg::array_sel_t           data_sel,
	input  logic [vertex_job_pkg::LINE_BITS-1:0] data_line,
	input  logic                                 line_clear,
	input  logic                                 shift,
	output logic [vertex_job_pkg::ELEM_BITS-1:0] element,
	output logic                                 line_loaded
);

	logic [vertex_job_pkg::LINE_BITS-1:0] line_reg;
	logic                                 load;

	assign load    = data_valid && (data_sel == ARRAY_SEL);
	// element 0 sits in the low bits
	assign element = line_reg[vertex_job_pkg::ELEM_BITS-1:0];

	always_ff @(posedge clock) begin
		if (load)
			line_reg <= data_line;
		else if (shift)
			line_reg <= line_reg >> vertex_job_pkg::ELEM_BITS;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			line_loaded <= 1'b0;
		else if (load)
			line_loaded <= 1'b1;
		else if (line_clear)
			line_loaded <= 1'b0;
	end

	// next line is only requested after the current one was drained
	a_no_load_over_line : assert property (@(posedge clock) disable iff (!rstn)
		load |-> !line_loaded);

endmodule

`default_nettype wire

// File: source/job_sequencer.sv
// job FSM: counts vertices, queues line read commands and paces the unpackers
`timescale 1ns/100ps
`default_nettype none

module job_sequencer (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  logic                                      job_valid,
	output logic                                      job_ready,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0]      out_degree_base,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0]      edges_idx_base,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0]     num_vertices,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0]     first_id,
	output logic                                      cmd_push,
	output vertex_job_pkg::read_cmd_t                 cmd_push_data,
	input  logic                                      cmd_empty,
	input  logic [vertex_job_pkg::VERT_FREE_BITS-1:0] vert_free,
	input  logic                                      out_degree_loaded,
	input  logic                                      edges_idx_loaded,
	output logic                                      line_clear,
	output logic                                      shift,
	output logic [vertex_job_pkg::COUNT_BITS-1:0]     first_id_out,
	output logic                                      busy
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LINE_CHECK,
		ST_CMD_OUT_DEG,
		ST_CMD_EDGES_IDX,
		ST_WAIT_DATA,
		ST_SHIFT,
		ST_DONE
	} seq_state_t;

	seq_state_t                                state;
	seq_state_t                                next_state;
	logic [vertex_job_pkg::COUNT_BITS-1:0]     remaining;
	logic [vertex_job_pkg::ADDR_BITS-1:0]      od_base_q;
	logic [vertex_job_pkg::ADDR_BITS-1:0]      ei_base_q;
	logic [vertex_job_pkg::ADDR_BITS-1:0]      line_offset;
	logic [vertex_job_pkg::COUNT_BITS-1:0]     line_id;
	logic [vertex_job_pkg::SIZE_BITS-1:0]      real_size;
	logic [vertex_job_pkg::SIZE_BITS-1:0]      line_size;
	logic [vertex_job_pkg::SIZE_BITS-1:0]      shift_cnt;
	logic [vertex_job_pkg::VERT_FREE_BITS-1:0] free_needed;
	logic                                      rec_pending;
	logic                                      job_accept;
	logic                                      line_start;
	logic                                      last_shift;

	assign job_ready  = (state == ST_IDLE);
	assign busy       = (state != ST_IDLE);
	assign job_accept = job_valid & job_ready;
	assign cmd_push   = (state == ST_CMD_OUT_DEG) | (state == ST_CMD_EDGES_IDX);
	assign shift      = (state == ST_SHIFT);
	assign last_shift = (shift_cnt == real_size - 1'b1);
	assign line_clear = shift & last_shift;
	assign first_id_out = line_id;

	// the record of the previous shift is still on its way into the queue
	assign free_needed = vertex_job_pkg::VERT_FREE_BITS'(vertex_job_pkg::ELEMS_PER_LINE)
		+ vertex_job_pkg::VERT_FREE_BITS'(rec_pending);
	assign line_size = (remaining > vertex_job_pkg::COUNT_BITS'(vertex_job_pkg::ELEMS_PER_LINE))
		? vertex_job_pkg::SIZE_BITS'(vertex_job_pkg::ELEMS_PER_LINE)
		: remaining[vertex_job_pkg::SIZE_BITS-1:0];
	assign line_start = (state == ST_LINE_CHECK) && (remaining != '0) && cmd_empty
		&& (vert_free >= free_needed);

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:          if (job_valid) next_state = ST_LINE_CHECK;
			ST_LINE_CHECK: begin
				if (remaining == '0)
					next_state = ST_DONE;
				else if (line_start)
					next_state = ST_CMD_OUT_DEG;
			end
			ST_CMD_OUT_DEG:   next_state = ST_CMD_EDGES_IDX;
			ST_CMD_EDGES_IDX: next_state = ST_WAIT_DATA;
			ST_WAIT_DATA: begin
				if (out_degree_loaded && edges_idx_loaded)
					next_state = ST_SHIFT;
			end
			ST_SHIFT:         if (last_shift) next_state = ST_LINE_CHECK;
			ST_DONE:          next_state = ST_IDLE;
			default:          next_state = ST_IDLE;
		endcase
	end

	always_comb begin
		cmd_push_data.real_size = real_size;
		if (state == ST_CMD_EDGES_IDX) begin
			cmd_push_data.addr = ei_base_q + line_offset;
			cmd_push_data.sel  = vertex_job_pkg::ARR_EDGES_IDX;
		end else begin
			cmd_push_data.addr = od_base_q + line_offset;
			cmd_push_data.sel  = vertex_job_pkg::ARR_OUT_DEGREE;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= ST_IDLE;
			remaining   <= '0;
			shift_cnt   <= '0;
			rec_pending <= 1'b0;
		end else begin
			state       <= next_state;
			rec_pending <= shift;
			if (job_accept)
				remaining <= num_vertices;
			else if (line_start)
				remaining <= remaining - vertex_job_pkg::COUNT_BITS'(line_size);
			shift_cnt <= (shift && !last_shift) ? shift_cnt + 1'b1 : '0;
		end
	end

	// job bases, line address and line id base
	always_ff @(posedge clock) begin
		if (job_accept) begin
			od_base_q   <= out_degree_base;
			ei_base_q   <= edges_idx_base;
			line_offset <= '0;
			line_id     <= first_id;
		end
		if (line_start)
			real_size <= line_size;
		if (state == ST_CMD_EDGES_IDX)
			line_offset <= line_offset + vertex_job_pkg::ADDR_BITS'(vertex_job_pkg::LINE_BYTES);
		if (line_clear)
			line_id <= line_id + vertex_job_pkg::COUNT_BITS'(real_size);
	end

	a_shift_needs_lines : assert property (@(posedge clock) disable iff (!rstn)
		shift |-> (out_degree_loaded && edges_idx_loaded));

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
// synchronous register FIFO with a typed payload, shared by the command and record queues
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  payload_t                     push_data,
	input  logic                         pop,
	output payload_t                     head,
	output logic                         valid,
	output logic                         empty,
	output logic [$clog2(DEPTH + 1)-1:0] free
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                full;
	logic                do_push;
	logic                do_pop;

	assign empty   = (count == '0);
	assign full    = (count == CNT_BITS'(DEPTH));
	assign valid   = ~empty;
	assign free    = CNT_BITS'(DEPTH) - count;
	assign head    = mem[rd_ptr];
	// pop only counts while the head is valid
	assign do_pop  = pop & valid;
	assign do_push = push & ~full;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// writers reserve room before pushing
	a_no_push_when_full : assert property (@(posedge clock) disable iff (!rstn)
		push |-> !full);

endmodule

`default_nettype wire

// File: source/vertex_job_pkg.sv
// shared widths, depths, array names and payload structs for the vertex job controller
`default_nettype none

package vertex_job_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and sizes
	//////////////////////////////////////////////////////////////////////

	// one array element, inverse degree or inverse edge index
	localparam int ELEM_BITS      = 32;
	localparam int ELEMS_PER_LINE = 8;
	localparam int LINE_BITS      = ELEM_BITS * ELEMS_PER_LINE;
	// byte size of a cacheline, also the line address step
	localparam int LINE_BYTES     = LINE_BITS / 8;

	localparam int ADDR_BITS      = 32;
	localparam int COUNT_BITS     = 16;

	// element count of one line, 1 to ELEMS_PER_LINE
	localparam int SIZE_BITS      = 4;

	//////////////////////////////////////////////////////////////////////
	// queue depths
	//////////////////////////////////////////////////////////////////////

	localparam int CMD_FIFO_DEPTH  = 4;
	localparam int VERT_FIFO_DEPTH = 32;
	// width of the record queue free slot count
	localparam int VERT_FREE_BITS  = $clog2(VERT_FIFO_DEPTH + 1);

	//////////////////////////////////////////////////////////////////////
	// payload types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		ARR_OUT_DEGREE = 1'b0,
		ARR_EDGES_IDX  = 1'b1
	} array_sel_t;

	// one line read request
	typedef struct packed {
		logic [ADDR_BITS-1:0] addr;
		array_sel_t           sel;
		// valid elements in this line
		logic [SIZE_BITS-1:0] real_size;
	} read_cmd_t;

	// one vertex record, 80 bits
	typedef struct packed {
		logic [COUNT_BITS-1:0] id;
		logic [ELEM_BITS-1:0]  inv_out_degree;
		logic [ELEM_BITS-1:0]  inv_edges_idx;
	} vertex_rec_t;

endpackage

`default_nettype wire
